// File: hdl/md5_pkg.sv
package md5_pkg;

    typedef logic [31:0] md5_word_t;

    // chaining and working state, a in the top bits
    typedef struct packed {
        md5_word_t a;
        md5_word_t b;
        md5_word_t c;
        md5_word_t d;
    } md5_state_t;

    // host write into the message buffer
    typedef struct packed {
        logic      we;
        logic [3:0] addr;
        md5_word_t data;
    } md5_wr_t;

    localparam md5_state_t MD5_INIT = '{
        a: 32'h67452301,
        b: 32'hefcdab89,
        c: 32'h98badcfe,
        d: 32'h10325476
    };

    localparam int ROUNDS = 64;
    localparam int CHUNK_WORDS = 16;

endpackage

// File: hdl/md5_const_rom.sv
module md5_const_rom (
    input  logic [5:0]         round,
    output md5_pkg::md5_word_t k,
    output logic [4:0]         shift
);

    logic [3:0][4:0] shift_row;

    always_comb begin
        case (round)
            6'd0:  k = 32'hd76aa478;
            6'd1:  k = 32'he8c7b756;
            6'd2:  k = 32'h242070db;
            6'd3:  k = 32'hc1bdceee;
            6'd4:  k = 32'hf57c0faf;
            6'd5:  k = 32'h4787c62a;
            6'd6:  k = 32'ha8304613;
            6'd7:  k = 32'hfd469501;
            6'd8:  k = 32'h698098d8;
            6'd9:  k = 32'h8b44f7af;
            6'd10: k = 32'hffff5bb1;
            6'd11: k = 32'h895cd7be;
            6'd12: k = 32'h6b901122;
            6'd13: k = 32'hfd987193;
            6'd14: k = 32'ha679438e;
            6'd15: k = 32'h49b40821;
            6'd16: k = 32'hf61e2562;
            6'd17: k = 32'hc040b340;
            6'd18: k = 32'h265e5a51;
            6'd19: k = 32'he9b6c7aa;
            6'd20: k = 32'hd62f105d;
            6'd21: k = 32'h02441453;
            6'd22: k = 32'hd8a1e681;
            6'd23: k = 32'he7d3fbc8;
            6'd24: k = 32'h21e1cde6;
            6'd25: k = 32'hc33707d6;
            6'd26: k = 32'hf4d50d87;
            6'd27: k = 32'h455a14ed;
            6'd28: k = 32'ha9e3e905;
            6'd29: k = 32'hfcefa3f8;
            6'd30: k = 32'h676f02d9;
            6'd31: k = 32'h8d2a4c8a;
            6'd32: k = 32'hfffa3942;
            6'd33: k = 32'h8771f681;
            6'd34: k = 32'h6d9d6122;
            6'd35: k = 32'hfde5380c;
            6'd36: k = 32'ha4beea44;
            6'd37: k = 32'h4bdecfa9;
            6'd38: k = 32'hf6bb4b60;
            6'd39: k = 32'hbebfbc70;
            6'd40: k = 32'h289b7ec6;
            6'd41: k = 32'heaa127fa;
            6'd42: k = 32'hd4ef3085;
            6'd43: k = 32'h04881d05;
            6'd44: k = 32'hd9d4d039;
            6'd45: k = 32'he6db99e5;
            6'd46: k = 32'h1fa27cf8;
            6'd47: k = 32'hc4ac5665;
            6'd48: k = 32'hf4292244;
            6'd49: k = 32'h432aff97;
            6'd50: k = 32'hab9423a7;
            6'd51: k = 32'hfc93a039;
            6'd52: k = 32'h655b59c3;
            6'd53: k = 32'h8f0ccc92;
            6'd54: k = 32'hffeff47d;
            6'd55: k = 32'h85845dd1;
            6'd56: k = 32'h6fa87e4f;
            6'd57: k = 32'hfe2ce6e0;
            6'd58: k = 32'ha3014314;
            6'd59: k = 32'h4e0811a1;
            6'd60: k = 32'hf7537e82;
            6'd61: k = 32'hbd3af235;
            6'd62: k = 32'h2ad7d2bb;
            default: k = 32'heb86d391;
        endcase
    end

    // one row of four shift amounts per round group, element 0 first
    always_comb begin
        case (round[5:4])
            2'd0:    shift_row = {5'd22, 5'd17, 5'd12, 5'd7};
            2'd1:    shift_row = {5'd20, 5'd14, 5'd9, 5'd5};
            2'd2:    shift_row = {5'd23, 5'd16, 5'd11, 5'd4};
            default: shift_row = {5'd21, 5'd15, 5'd10, 5'd6};
        endcase
    end

    assign shift = shift_row[round[1:0]];

endmodule

// File: hdl/md5_round_logic.sv
module md5_round_logic (
    input  logic [5:0]         round,
    input  md5_pkg::md5_word_t b,
    input  md5_pkg::md5_word_t c,
    input  md5_pkg::md5_word_t d,
    output md5_pkg::md5_word_t f,
    output logic [3:0]         g
);

    logic [3:0] i;

    assign i = round[3:0];

    // g wraps modulo 16 through the 4-bit width
    always_comb begin
        case (round[5:4])
            2'd0: begin
                f = (b & c) | (~b & d);
                g = i;
            end
            2'd1: begin
                f = (b & d) | (c & ~d);
                g = (i << 2) + i + 4'd1;
            end
            2'd2: begin
                f = b ^ c ^ d;
                g = (i << 1) + i + 4'd5;
            end
            default: begin
                f = c ^ (b | ~d);
                g = (i << 3) - i;
            end
        endcase
    end

endmodule

// File: hdl/md5_msg_buffer.sv
module md5_msg_buffer (
    input  logic               clk,
    input  md5_pkg::md5_wr_t   wr,
    input  logic [3:0]         raddr,
    output md5_pkg::md5_word_t rdata
);

    import md5_pkg::*;

    md5_word_t mem [CHUNK_WORDS];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port feeds the cruncher directly
    assign rdata = mem[raddr];

endmodule

// File: hdl/md5_chunk_cruncher.sv
module md5_chunk_cruncher (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               new_message,
    output logic               done,
    output md5_pkg::md5_state_t digest,
    output md5_pkg::md5_state_t work,
    output logic [5:0]         round,
    input  md5_pkg::md5_word_t k,
    input  logic [4:0]         shift,
    input  md5_pkg::md5_word_t f,
    input  md5_pkg::md5_word_t mdata
);

    import md5_pkg::*;

    typedef enum logic [1:0] {
        CRUNCH,
        FINALIZE,
        FINISHED
    } stage_t;

    stage_t     stage;
    logic [1:0] step;
    logic [5:0] round_next;
    md5_state_t chain;
    md5_state_t start_state;
    md5_word_t  t0;
    md5_word_t  op_a;
    md5_word_t  op_b;
    md5_word_t  op_a_next;
    md5_word_t  op_b_next;
    md5_word_t  sum;
    logic [63:0] rot_wide;
    md5_word_t  rotated;

    // the one shared adder
    assign sum = op_a + op_b;

    // upper half of the doubled word is the left rotate
    assign rot_wide = {sum, sum} << shift;
    assign rotated = rot_wide[63:32];

    assign start_state = new_message ? MD5_INIT : chain;
    assign round_next = (round == 6'(ROUNDS - 1)) ? 6'd0 : round + 6'd1;

    assign done = (stage == FINISHED);
    assign digest = chain;

    // operands for the step that follows this edge
    always_comb begin
        op_a_next = op_a;
        op_b_next = op_b;
        if (start) begin
            op_a_next = start_state.a;
            op_b_next = k;
        end else if (stage == CRUNCH) begin
            case (step)
                2'd0: begin
                    op_a_next = f;
                    op_b_next = mdata;
                end
                2'd1: begin
                    op_a_next = t0;
                    op_b_next = sum;
                end
                2'd2: begin
                    op_a_next = work.b;
                    op_b_next = rotated;
                end
                default: begin
                    // d becomes the next a; round already points at the next K
                    if (round == 6'd0) begin
                        op_a_next = chain.a;
                        op_b_next = work.d;
                    end else begin
                        op_a_next = work.d;
                        op_b_next = k;
                    end
                end
            endcase
        end else if (stage == FINALIZE) begin
            case (step)
                2'd0: begin
                    op_a_next = chain.b;
                    op_b_next = work.b;
                end
                2'd1: begin
                    op_a_next = chain.c;
                    op_b_next = work.c;
                end
                2'd2: begin
                    op_a_next = chain.d;
                    op_b_next = work.d;
                end
                default: begin
                    op_a_next = op_a;
                    op_b_next = op_b;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        op_a <= op_a_next;
        op_b <= op_b_next;
        if (start) begin
            work <= start_state;
        end else if (stage == CRUNCH) begin
            if (step == 2'd0) begin
                t0 <= sum;
            end
            if (step == 2'd3) begin
                work.a <= work.d;
                work.b <= sum;
                work.c <= work.b;
                work.d <= work.c;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= FINISHED;
            step <= 2'd0;
            round <= 6'd0;
            chain <= MD5_INIT;
        end else if (start) begin
            stage <= CRUNCH;
            step <= 2'd0;
            round <= 6'd0;
            // a new message restarts the chain from the initial values
            chain <= start_state;
        end else if (stage == CRUNCH) begin
            step <= step + 2'd1;
            if (step == 2'd2) begin
                round <= round_next;
            end
            // round has wrapped once the last round reaches step 3
            if (step == 2'd3 && round == 6'd0) begin
                stage <= FINALIZE;
            end
        end else if (stage == FINALIZE) begin
            step <= step + 2'd1;
            case (step)
                2'd0: chain.a <= sum;
                2'd1: chain.b <= sum;
                2'd2: chain.c <= sum;
                default: begin
                    chain.d <= sum;
                    stage <= FINISHED;
                end
            endcase
        end
    end

    busy_time: assert property (@(posedge clk) disable iff (reset)
        start |=> (!done) [* 4 * ROUNDS + 4] ##1 done)
        else $error("done not low for exactly %0d cycles", 4 * ROUNDS + 4);

    start_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> done)
        else $error("start while a chunk is in progress");

endmodule

// File: hdl/md5_core.sv
module md5_core (
    input  logic                clk,
    input  logic                reset,
    input  md5_pkg::md5_wr_t    wr,
    input  logic                start,
    input  logic                new_message,
    output logic                done,
    output md5_pkg::md5_state_t digest
);

    import md5_pkg::*;

    logic [5:0] round;
    logic [4:0] shift;
    logic [3:0] g;
    md5_word_t  k;
    md5_word_t  f;
    md5_word_t  mdata;
    md5_state_t work;

    md5_msg_buffer u_buffer (
        .clk   (clk),
        .wr    (wr),
        .raddr (g),
        .rdata (mdata)
    );

    md5_const_rom u_rom (
        .round (round),
        .k     (k),
        .shift (shift)
    );

    // f and g come from the working b, c, d of the current round
    md5_round_logic u_round_logic (
        .round (round),
        .b     (work.b),
        .c     (work.c),
        .d     (work.d),
        .f     (f),
        .g     (g)
    );

    md5_chunk_cruncher u_cruncher (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .new_message (new_message),
        .done        (done),
        .digest      (digest),
        .work        (work),
        .round       (round),
        .k           (k),
        .shift       (shift),
        .f           (f),
        .mdata       (mdata)
    );

    // the buffer is read every cycle while busy
    write_idle: assert property (@(posedge clk) disable iff (reset)
        wr.we |-> done)
        else $error("buffer write while a chunk is in progress");

endmodule

// File: sim/md5_checker.sv
module md5_checker (
    input  logic                clk,
    input  logic                reset,
    input  md5_pkg::md5_wr_t    wr,
    input  logic                start,
    input  logic                new_message,
    input  logic                done,
    input  md5_pkg::md5_state_t digest,
    output int                  tests,
    output int                  checks,
    output int                  failures
);

    timeunit 1ns;
    timeprecision 1ps;

    import md5_pkg::*;

    localparam int SHIFT_TAB [16] = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
    localparam int BUSY_CYCLES = 4 * ROUNDS + 4;

    // "abc" after padding, and its published digest as chaining words
    localparam logic [15:0][31:0] ABC_MSG = {32'h0, 32'h18, {13{32'h0}}, 32'h80636261};
    localparam md5_state_t ABC_DIGEST = '{
        a: 32'h98500190,
        b: 32'hb04fd23c,
        c: 32'h7d3f96d6,
        d: 32'h727fe128
    };

    logic [15:0][31:0] mirror;
    md5_state_t        chain;
    md5_state_t        expected;
    logic              pending_nm;
    logic              prev_done;
    logic              start_seen;
    logic              was_reset;
    int                busy_cycles;
    int                failures_before;

    // 64 rounds of MD5 on one chunk, added into the incoming chain
    function automatic md5_state_t md5_reference(input md5_state_t h,
                                                 input logic [15:0][31:0] m);
        md5_word_t  a;
        md5_word_t  b;
        md5_word_t  c;
        md5_word_t  d;
        md5_word_t  fv;
        md5_word_t  kv;
        md5_word_t  tmp;
        md5_state_t r;
        real        sv;
        int         gi;
        int         s;
        a = h.a;
        b = h.b;
        c = h.c;
        d = h.d;
        for (int i = 0; i < ROUNDS; i++) begin
            case (i / 16)
                0: begin
                    fv = (b & c) | (~b & d);
                    gi = i;
                end
                1: begin
                    fv = (b & d) | (c & ~d);
                    gi = (5 * i + 1) % 16;
                end
                2: begin
                    fv = b ^ c ^ d;
                    gi = (3 * i + 5) % 16;
                end
                default: begin
                    fv = c ^ (b | ~d);
                    gi = (7 * i) % 16;
                end
            endcase
            // K is the integer part of |sin(i + 1)| * 2^32
            sv = $sin(real'(i + 1));
            if (sv < 0.0) begin
                sv = -sv;
            end
            kv = 32'(longint'($floor(sv * 4294967296.0)));
            s = SHIFT_TAB[(i / 16) * 4 + i % 4];
            tmp = a + fv + kv + m[gi];
            a = d;
            d = c;
            c = b;
            b = b + ((tmp << s) | (tmp >> (32 - s)));
        end
        r.a = h.a + a;
        r.b = h.b + b;
        r.c = h.c + c;
        r.d = h.d + d;
        return r;
    endfunction

    task automatic record_check(input bit ok, input string msg);
        checks++;
        if (!ok) begin
            failures++;
            $display("CHECK FAILED at %0d ns: %s", $time, msg);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            chain = MD5_INIT;
            pending_nm = 1'b0;
            prev_done = 1'b1;
            start_seen = 1'b0;
            was_reset = 1'b1;
            busy_cycles = 0;
            tests = 0;
            checks = 0;
            failures = 0;
        end else begin
            if (was_reset) begin
                failures_before = failures;
                record_check(done === 1'b1, "done not high after reset");
                record_check(digest === MD5_INIT,
                             $sformatf("digest %h after reset, expected %h", digest, MD5_INIT));
                tests++;
                $display("test %0d reset state: %s", tests,
                         (failures == failures_before) ? "ok" : "mismatch");
                was_reset = 1'b0;
            end
            if (start_seen) begin
                record_check(!done, "done did not fall after start");
            end
            if (!done) begin
                busy_cycles++;
            end
            if (done && !prev_done) begin
                failures_before = failures;
                if (pending_nm) begin
                    chain = MD5_INIT;
                end
                expected = md5_reference(chain, mirror);
                chain = expected;
                record_check(digest === expected,
                             $sformatf("digest %h, expected %h", digest, expected));
                record_check(busy_cycles == BUSY_CYCLES,
                             $sformatf("done low for %0d cycles, expected %0d",
                                       busy_cycles, BUSY_CYCLES));
                if (pending_nm && mirror == ABC_MSG) begin
                    record_check(digest === ABC_DIGEST,
                                 $sformatf("abc digest %h, expected %h", digest, ABC_DIGEST));
                end
                tests++;
                $display("test %0d chunk new_message %0b digest %h: %s", tests, pending_nm,
                         digest, (failures == failures_before) ? "ok" : "mismatch");
            end
            if (wr.we) begin
                mirror[wr.addr] = wr.data;
            end
            if (start) begin
                pending_nm = new_message;
                busy_cycles = 0;
            end
            start_seen = start;
            prev_done = done;
        end
    end

endmodule

// File: sim/md5_tb.sv
module md5_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import md5_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam logic [15:0] LFSR_SEED = 16'd27105;
    localparam int RANDOM_CHUNKS = 4;
    localparam int CHAIN_CHUNKS = 3;
    // abc, random singles, chained chunks, reload chunk
    localparam int NUM_CHUNKS = 1 + RANDOM_CHUNKS + CHAIN_CHUNKS + 1;
    localparam int EXPECTED_TESTS = NUM_CHUNKS + 1;
    localparam int TIMEOUT_CYCLES = NUM_CHUNKS * (4 * ROUNDS + 4 + 20) + RESET_CYCLES + 200;

    logic              clk;
    logic              reset;
    md5_wr_t           wr;
    logic              start;
    logic              new_message;
    logic              done;
    md5_state_t        digest;
    logic [15:0]       lfsr;
    logic [15:0][31:0] msg;
    int                tests;
    int                checks;
    int                failures;

    md5_core DUT (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .start       (start),
        .new_message (new_message),
        .done        (done),
        .digest      (digest)
    );

    md5_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .start       (start),
        .new_message (new_message),
        .done        (done),
        .digest      (digest),
        .tests       (tests),
        .checks      (checks),
        .failures    (failures)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic fill_random(output logic [15:0][31:0] words);
        for (int i = 0; i < CHUNK_WORDS; i++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_next(lfsr);
                words[i][b] = lfsr[0];
            end
        end
    endtask

    task automatic run_chunk(input logic [15:0][31:0] words, input logic nm);
        for (int i = 0; i < CHUNK_WORDS; i++) begin
            @(negedge clk);
            wr.we = 1'b1;
            wr.addr = 4'(i);
            wr.data = words[i];
        end
        @(negedge clk);
        wr = '0;
        start = 1'b1;
        new_message = nm;
        @(negedge clk);
        start = 1'b0;
        new_message = 1'b0;
        wait (done);
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        wr = '0;
        start = 1'b0;
        new_message = 1'b0;
        lfsr = LFSR_SEED;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        // padded "abc", one chunk
        msg = '0;
        msg[0] = 32'h80636261;
        msg[14] = 32'd24;
        run_chunk(msg, 1'b1);
        repeat (RANDOM_CHUNKS) begin
            fill_random(msg);
            run_chunk(msg, 1'b1);
        end
        // chained message, then a fresh one without reset
        for (int n = 0; n < CHAIN_CHUNKS; n++) begin
            fill_random(msg);
            run_chunk(msg, n == 0);
        end
        fill_random(msg);
        run_chunk(msg, 1'b1);
        repeat (4) @(negedge clk);
        $display("tests %0d, checks %0d, failures %0d", tests, checks, failures);
        if (failures == 0 && tests == EXPECTED_TESTS) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (tests != EXPECTED_TESTS) begin
                $display("checker finished %0d of %0d tests", tests, EXPECTED_TESTS);
            end
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: done never rose within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: list.f
hdl/md5_pkg.sv
hdl/md5_const_rom.sv
hdl/md5_round_logic.sv
hdl/md5_msg_buffer.sv
hdl/md5_chunk_cruncher.sv
hdl/md5_core.sv
sim/md5_checker.sv
sim/md5_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= md5_tb
FILELIST  ?= list.f
PASS_LINE  = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
